//--- hdl/mem_pkg.sv
// Shared bus data types, access size codes, region codes and I/O word indices
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;    // Bus data word
    typedef logic [15:0] half_t;    // Register half
    typedef logic [3:0]  byte_en_t; // One enable per byte lane

    // Access width, little endian lanes
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    // Top address byte of each bus region
    localparam logic [7:0] REGION_INTERN  = 8'h03;
    localparam logic [7:0] REGION_IO      = 8'h04;
    localparam logic [7:0] REGION_PALETTE = 8'h05;

    // Object palette sits above the background palette
    localparam logic [9:0] PALETTE_OBJ_OFFSET = 10'h200;

    // Word positions inside the I/O region
    localparam int IO_KEYINPUT_IDX = 0;
    localparam int IO_IE_IF_IDX    = 1;
    localparam int IO_SOUNDCNT_IDX = 2;
    localparam int IO_FIFO_A_IDX   = 3;
    localparam int IO_FIFO_B_IDX   = 4;

    // Sound control bits that restart the DMA sound sequencers
    localparam int SQ_RESET_A_BIT = 27;
    localparam int SQ_RESET_B_BIT = 31;

endpackage

`default_nettype wire

//--- hdl/bus_front.sv
// Bus front end with write latch, write pause, byte-enable decode and RAM address select
`timescale 1ns/1ps
`default_nettype none

module bus_front (
    input  logic              clock,
    input  logic              reset,
    input  mem_pkg::word_t    bus_addr,
    input  mem_pkg::mem_size_t bus_size,
    input  logic              bus_write,
    output logic              bus_pause,
    output mem_pkg::word_t    addr_lat,
    output logic              write_lat,
    output mem_pkg::byte_en_t byte_en,
    output mem_pkg::word_t    ram_addr
);

    mem_pkg::mem_size_t size_lat;
    logic               write_start;

    // A new write is only taken while not already paused
    assign write_start = bus_write & ~bus_pause;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            addr_lat  <= '0;
            size_lat  <= mem_pkg::size_byte;
            write_lat <= 1'b0;
            bus_pause <= 1'b0;
        end else begin
            addr_lat  <= bus_addr;
            size_lat  <= bus_size;
            write_lat <= write_start;
            bus_pause <= write_start; // Stall the driver for the write cycle
        end
    end

    // Lane enables from the latched size and low address bits
    always_comb begin
        byte_en = '0;
        if (write_lat) begin
            case (size_lat)
                mem_pkg::size_word: byte_en = 4'b1111;
                mem_pkg::size_half: byte_en = addr_lat[1] ? 4'b1100 : 4'b0011;
                default:            byte_en = 4'b0001 << addr_lat[1:0];
            endcase
        end
    end

    // Reads use the live address so RAM data is ready one cycle later
    assign ram_addr = write_lat ? addr_lat : bus_addr;

endmodule

`default_nettype wire

//--- hdl/dual_port_ram.sv
// Block RAM with a byte-writable write-first bus port and a read-only graphics port
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter int ADDR_BITS = 7
) (
    input  logic                 clock,
    input  logic [ADDR_BITS-1:0] bus_index,
    input  mem_pkg::byte_en_t    bus_we,
    input  mem_pkg::word_t       bus_wdata,
    output mem_pkg::word_t       bus_rdata,
    input  logic [ADDR_BITS-1:0] gfx_index,
    output mem_pkg::word_t       gfx_rdata
);

    mem_pkg::word_t mem [2**ADDR_BITS];
    mem_pkg::word_t merged;

    // Stored word with the enabled lanes replaced
    always_comb begin
        merged = mem[bus_index];
        for (int lane = 0; lane < 4; lane++) begin
            if (bus_we[lane])
                merged[8*lane +: 8] = bus_wdata[8*lane +: 8];
        end
    end

    always_ff @(posedge clock) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (bus_we[lane])
                mem[bus_index][8*lane +: 8] <= bus_wdata[8*lane +: 8];
        end
        bus_rdata <= merged; // Write first
    end

    always_ff @(posedge clock) begin
        gfx_rdata <= mem[gfx_index];
    end

endmodule

`default_nettype wire

//--- hdl/ram_regions.sv
// Internal RAM and palette RAM regions with write decode and bus read select
`timescale 1ns/1ps
`default_nettype none

module ram_regions #(
    parameter int INTERN_ADDR_BITS  = 13,
    parameter int PALETTE_ADDR_BITS = 7
) (
    input  logic                         clock,
    input  mem_pkg::word_t               addr_lat,
    input  mem_pkg::word_t               ram_addr,
    input  mem_pkg::byte_en_t            byte_en,
    input  mem_pkg::word_t               bus_wdata,
    input  logic [PALETTE_ADDR_BITS-1:0] gfx_palette_bg_addr,
    input  logic [PALETTE_ADDR_BITS-1:0] gfx_palette_obj_addr,
    output mem_pkg::word_t               gfx_palette_bg_data,
    output mem_pkg::word_t               gfx_palette_obj_data,
    output mem_pkg::word_t               ram_rdata,
    output logic                         ram_hit
);

    logic              in_intern, in_palette, in_bg, in_obj;
    mem_pkg::word_t    obj_addr;
    mem_pkg::byte_en_t intern_we, bg_we, obj_we;
    mem_pkg::word_t    intern_rdata, bg_rdata, obj_rdata;

    assign in_intern  = addr_lat[31:24] == mem_pkg::REGION_INTERN;
    assign in_palette = addr_lat[31:24] == mem_pkg::REGION_PALETTE;
    assign in_obj     = in_palette && (addr_lat[9:0] >= mem_pkg::PALETTE_OBJ_OFFSET);
    assign in_bg      = in_palette && !in_obj;
    assign ram_hit    = in_intern | in_palette;

    assign intern_we = in_intern ? byte_en : '0;
    assign bg_we     = in_bg ? byte_en : '0;
    assign obj_we    = in_obj ? byte_en : '0;

    // Object palette is indexed from its own base
    assign obj_addr = ram_addr - mem_pkg::word_t'(mem_pkg::PALETTE_OBJ_OFFSET);

    dual_port_ram #(.ADDR_BITS(INTERN_ADDR_BITS)) intern_ram (
        .clock,
        .bus_index (ram_addr[INTERN_ADDR_BITS+1:2]),
        .bus_we    (intern_we),
        .bus_wdata,
        .bus_rdata (intern_rdata),
        .gfx_index ('0),          // No graphics reader
        .gfx_rdata ()
    );

    dual_port_ram #(.ADDR_BITS(PALETTE_ADDR_BITS)) palette_bg_ram (
        .clock,
        .bus_index (ram_addr[PALETTE_ADDR_BITS+1:2]),
        .bus_we    (bg_we),
        .bus_wdata,
        .bus_rdata (bg_rdata),
        .gfx_index (gfx_palette_bg_addr),
        .gfx_rdata (gfx_palette_bg_data)
    );

    dual_port_ram #(.ADDR_BITS(PALETTE_ADDR_BITS)) palette_obj_ram (
        .clock,
        .bus_index (obj_addr[PALETTE_ADDR_BITS+1:2]),
        .bus_we    (obj_we),
        .bus_wdata,
        .bus_rdata (obj_rdata),
        .gfx_index (gfx_palette_obj_addr),
        .gfx_rdata (gfx_palette_obj_data)
    );

    always_comb begin
        if (in_intern)
            ram_rdata = intern_rdata;
        else if (in_obj)
            ram_rdata = obj_rdata;
        else if (in_bg)
            ram_rdata = bg_rdata;
        else
            ram_rdata = '0;
    end

endmodule

`default_nettype wire

//--- hdl/sound_fifo.sv
// Circular sound FIFO with clear, entry count and combinational head
`timescale 1ns/1ps
`default_nettype none

module sound_fifo #(
    parameter int DEPTH = 8
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           push,
    input  logic           pop,
    input  logic           clear,
    input  mem_pkg::word_t push_data,
    output mem_pkg::word_t head,
    output logic [3:0]     size
);

    localparam int PTR_BITS = $clog2(DEPTH);

    mem_pkg::word_t      entries [DEPTH];
    logic [PTR_BITS-1:0] get_ptr, put_ptr;
    logic                full, empty, do_push, do_pop;

    assign empty   = size == 4'd0;
    assign full    = size == 4'(DEPTH);
    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop); // Full slot frees on a pop
    assign head    = entries[get_ptr];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            get_ptr <= '0;
            put_ptr <= '0;
            size    <= '0;
        end else if (clear) begin
            get_ptr <= '0;
            put_ptr <= '0;
            size    <= '0;
        end else begin
            if (do_push)
                put_ptr <= (put_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : put_ptr + 1'b1;
            if (do_pop)
                get_ptr <= (get_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : get_ptr + 1'b1;
            if (do_push && !do_pop)
                size <= size + 4'd1;
            else if (do_pop && !do_push)
                size <= size - 4'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_push && !clear)
            entries[put_ptr] <= push_data;
    end

endmodule

`default_nettype wire

//--- hdl/io_registers.sv
// I/O register words, interrupt enable and acknowledge, sound control and sound FIFOs
`timescale 1ns/1ps
`default_nettype none

module io_registers #(
    parameter int IO_WORDS   = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  mem_pkg::word_t    addr_lat,
    input  mem_pkg::byte_en_t byte_en,
    input  mem_pkg::word_t    bus_wdata,
    input  mem_pkg::half_t    buttons,
    input  mem_pkg::half_t    reg_if,
    input  logic              fifo_read_a,
    input  logic              fifo_read_b,
    input  logic              fifo_clear_a,
    input  logic              fifo_clear_b,
    output mem_pkg::word_t    io_rdata,
    output logic              io_hit,
    output mem_pkg::half_t    int_enable,
    output mem_pkg::half_t    int_acks,
    output logic              sq_reset_a,
    output logic              sq_reset_b,
    output mem_pkg::word_t    fifo_data_a,
    output mem_pkg::word_t    fifo_data_b,
    output logic [3:0]        fifo_size_a,
    output logic [3:0]        fifo_size_b
);

    localparam int IDX_BITS = $clog2(IO_WORDS);

    logic [IDX_BITS-1:0] word_sel;
    mem_pkg::byte_en_t   word_we  [IO_WORDS];
    mem_pkg::word_t      regs     [IO_WORDS];
    mem_pkg::word_t      rd_words [IO_WORDS];

    assign io_hit   = (addr_lat[31:24] == mem_pkg::REGION_IO) && (addr_lat[23:2] < IO_WORDS);
    assign word_sel = addr_lat[IDX_BITS+1:2];
    assign io_rdata = io_hit ? rd_words[word_sel] : '0;

    for (genvar i = 0; i < IO_WORDS; i++) begin : g_word
        // Writable lanes of each word
        localparam logic [3:0] LANES =
            (i == mem_pkg::IO_KEYINPUT_IDX) ? 4'b1100 :
            (i == mem_pkg::IO_IE_IF_IDX)    ? 4'b0011 :
            (i == mem_pkg::IO_FIFO_A_IDX || i == mem_pkg::IO_FIFO_B_IDX) ? 4'b0000 :
            4'b1111;

        assign word_we[i] = (io_hit && word_sel == i) ? byte_en : '0;

        always_ff @(posedge clock, posedge reset) begin
            if (reset) begin
                regs[i] <= '0;
            end else begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (word_we[i][lane] && LANES[lane])
                        regs[i][8*lane +: 8] <= bus_wdata[8*lane +: 8];
                end
            end
        end

        if (i == mem_pkg::IO_KEYINPUT_IDX) begin : g_key
            assign rd_words[i] = {regs[i][31:16], buttons}; // Low half is live keys
        end else if (i == mem_pkg::IO_IE_IF_IDX) begin : g_ie_if
            assign rd_words[i] = {reg_if, regs[i][15:0]};
        end else if (i == mem_pkg::IO_FIFO_A_IDX) begin : g_fifo_a
            assign rd_words[i] = fifo_data_a;
        end else if (i == mem_pkg::IO_FIFO_B_IDX) begin : g_fifo_b
            assign rd_words[i] = fifo_data_b;
        end else begin : g_plain
            assign rd_words[i] = regs[i];
        end
    end

    assign int_enable = regs[mem_pkg::IO_IE_IF_IDX][15:0];

    // Acknowledge bits live for one cycle after the IF half is written
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            int_acks <= '0;
        end else begin
            int_acks[7:0]  <= word_we[mem_pkg::IO_IE_IF_IDX][2] ? bus_wdata[23:16] : 8'd0;
            int_acks[15:8] <= word_we[mem_pkg::IO_IE_IF_IDX][3] ? bus_wdata[31:24] : 8'd0;
        end
    end

    assign sq_reset_a = word_we[mem_pkg::IO_SOUNDCNT_IDX][3] & bus_wdata[mem_pkg::SQ_RESET_A_BIT];
    assign sq_reset_b = word_we[mem_pkg::IO_SOUNDCNT_IDX][3] & bus_wdata[mem_pkg::SQ_RESET_B_BIT];

    sound_fifo #(.DEPTH(FIFO_DEPTH)) fifo_a (
        .clock,
        .reset,
        .push      (word_we[mem_pkg::IO_FIFO_A_IDX][0]),
        .pop       (fifo_read_a),
        .clear     (fifo_clear_a),
        .push_data (bus_wdata),
        .head      (fifo_data_a),
        .size      (fifo_size_a)
    );

    sound_fifo #(.DEPTH(FIFO_DEPTH)) fifo_b (
        .clock,
        .reset,
        .push      (word_we[mem_pkg::IO_FIFO_B_IDX][0]),
        .pop       (fifo_read_b),
        .clear     (fifo_clear_b),
        .push_data (bus_wdata),
        .head      (fifo_data_b),
        .size      (fifo_size_b)
    );

endmodule

`default_nettype wire

//--- hdl/read_mux.sv
// Bus read data select with the DMA preempt hold register
`timescale 1ns/1ps
`default_nettype none

module read_mux (
    input  logic           clock,
    input  logic           reset,
    input  logic           ram_hit,
    input  logic           io_hit,
    input  logic           dma_active,
    input  mem_pkg::word_t ram_rdata,
    input  mem_pkg::word_t io_rdata,
    output mem_pkg::word_t bus_rdata
);

    logic           dma_lat, dma_rise, dma_fall, use_held;
    mem_pkg::word_t sel_rdata, cpu_rdata;

    assign sel_rdata = ram_hit ? ram_rdata : io_hit ? io_rdata : '0;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            dma_lat  <= 1'b0;
            use_held <= 1'b0;
        end else begin
            dma_lat  <= dma_active;
            use_held <= dma_fall; // Held word shows the cycle after the fall
        end
    end

    assign dma_rise = dma_active & ~dma_lat;
    assign dma_fall = dma_lat & ~dma_active;

    // Word the CPU was waiting on when DMA took the bus
    always_ff @(posedge clock) begin
        if (dma_rise)
            cpu_rdata <= bus_rdata;
    end

    assign bus_rdata = use_held ? cpu_rdata : sel_rdata;

endmodule

`default_nettype wire

//--- hdl/mem_top.sv
// Memory controller top with bus front end, RAM regions, I/O registers and read select
`timescale 1ns/1ps
`default_nettype none

module mem_top #(
    parameter int INTERN_ADDR_BITS  = 13,
    parameter int PALETTE_ADDR_BITS = 7,
    parameter int IO_WORDS          = 8,
    parameter int FIFO_DEPTH        = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  mem_pkg::word_t               bus_addr,
    input  mem_pkg::word_t               bus_wdata,
    input  mem_pkg::mem_size_t           bus_size,
    input  logic                         bus_write,
    input  logic                         dma_active,
    output mem_pkg::word_t               bus_rdata,
    output logic                         bus_pause,
    input  logic [PALETTE_ADDR_BITS-1:0] gfx_palette_bg_addr,
    input  logic [PALETTE_ADDR_BITS-1:0] gfx_palette_obj_addr,
    output mem_pkg::word_t               gfx_palette_bg_data,
    output mem_pkg::word_t               gfx_palette_obj_data,
    input  mem_pkg::half_t               buttons,
    input  mem_pkg::half_t               reg_if,
    output mem_pkg::half_t               int_enable,
    output mem_pkg::half_t               int_acks,
    output logic                         sq_reset_a,
    output logic                         sq_reset_b,
    input  logic                         fifo_read_a,
    input  logic                         fifo_read_b,
    input  logic                         fifo_clear_a,
    input  logic                         fifo_clear_b,
    output mem_pkg::word_t               fifo_data_a,
    output mem_pkg::word_t               fifo_data_b,
    output logic [3:0]                   fifo_size_a,
    output logic [3:0]                   fifo_size_b
);

    mem_pkg::word_t    addr_lat, ram_addr, ram_rdata, io_rdata;
    mem_pkg::byte_en_t byte_en;
    logic              ram_hit, io_hit;

    bus_front front (
        .clock, .reset, .bus_addr, .bus_size, .bus_write,
        .bus_pause, .addr_lat, .write_lat (), .byte_en, .ram_addr
    );

    ram_regions #(
        .INTERN_ADDR_BITS  (INTERN_ADDR_BITS),
        .PALETTE_ADDR_BITS (PALETTE_ADDR_BITS)
    ) rams (
        .clock, .addr_lat, .ram_addr, .byte_en, .bus_wdata,
        .gfx_palette_bg_addr, .gfx_palette_obj_addr,
        .gfx_palette_bg_data, .gfx_palette_obj_data,
        .ram_rdata, .ram_hit
    );

    io_registers #(
        .IO_WORDS   (IO_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) io (
        .clock, .reset, .addr_lat, .byte_en, .bus_wdata, .buttons, .reg_if,
        .fifo_read_a, .fifo_read_b, .fifo_clear_a, .fifo_clear_b,
        .io_rdata, .io_hit, .int_enable, .int_acks, .sq_reset_a, .sq_reset_b,
        .fifo_data_a, .fifo_data_b, .fifo_size_a, .fifo_size_b
    );

    read_mux rd_mux (
        .clock, .reset, .ram_hit, .io_hit, .dma_active,
        .ram_rdata, .io_rdata, .bus_rdata
    );

endmodule

`default_nettype wire

//--- sim/tb_mem_top.sv
// Directed testbench for the memory controller with bus tasks, reference models and checks
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top;

    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT    = 50; // Cycles allowed for any wait
    localparam mem_pkg::word_t IO_BASE = {mem_pkg::REGION_IO, 24'h0};
    localparam mem_pkg::word_t SQ_BITS =
        (32'd1 << mem_pkg::SQ_RESET_A_BIT) | (32'd1 << mem_pkg::SQ_RESET_B_BIT);

    logic               clock = 1'b0;
    logic               reset;
    mem_pkg::word_t     bus_addr, bus_wdata, bus_rdata, gfx_bg_data, gfx_obj_data;
    mem_pkg::mem_size_t bus_size;
    logic               bus_write, dma_active, bus_pause, sq_reset_a, sq_reset_b;
    logic [6:0]         gfx_bg_addr, gfx_obj_addr;
    mem_pkg::half_t     buttons, reg_if, int_enable, int_acks;
    logic [1:0]         fifo_read, fifo_clear; // Bit 0 drives FIFO A, bit 1 FIFO B
    mem_pkg::word_t     fifo_data_a, fifo_data_b;
    logic [3:0]         fifo_size_a, fifo_size_b;

    mem_pkg::word_t ram_ref [3][16]; // Internal RAM, background and object palette words
    mem_pkg::word_t fifo_ref [$];
    logic           sq_seen_a, sq_seen_b;
    mem_pkg::half_t ack_seen;
    int unsigned    seed;

    mem_top DUT (
        .clock, .reset, .bus_addr, .bus_wdata, .bus_size, .bus_write, .dma_active,
        .bus_rdata, .bus_pause,
        .gfx_palette_bg_addr (gfx_bg_addr), .gfx_palette_obj_addr (gfx_obj_addr),
        .gfx_palette_bg_data (gfx_bg_data), .gfx_palette_obj_data (gfx_obj_data),
        .buttons, .reg_if, .int_enable, .int_acks, .sq_reset_a, .sq_reset_b,
        .fifo_read_a (fifo_read[0]), .fifo_read_b (fifo_read[1]),
        .fifo_clear_a (fifo_clear[0]), .fifo_clear_b (fifo_clear[1]),
        .fifo_data_a, .fifo_data_b, .fifo_size_a, .fifo_size_b
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Lanes touched by an access of this size at this offset
    function automatic logic [3:0] lanes_for(mem_pkg::mem_size_t size, logic [1:0] offset);
        case (size)
            mem_pkg::size_word: return 4'b1111;
            mem_pkg::size_half: return offset[1] ? 4'b1100 : 4'b0011;
            default:            return 4'b0001 << offset;
        endcase
    endfunction

    function automatic mem_pkg::word_t ram_addr_of(int region, int idx);
        mem_pkg::word_t base;
        base = {(region == 0) ? mem_pkg::REGION_INTERN : mem_pkg::REGION_PALETTE, 24'h0};
        if (region == 2)
            base = base + mem_pkg::PALETTE_OBJ_OFFSET; // Object palette above background
        return base + 4 * idx;
    endfunction

    // Writes wait for pause, which must stay high for one cycle only
    task automatic write_bus(input mem_pkg::word_t addr, input mem_pkg::word_t data,
                             input mem_pkg::mem_size_t size);
        int waited;
        int high;
        bus_addr  = addr;
        bus_wdata = data;
        bus_size  = size;
        bus_write = 1'b1;
        waited    = 0;
        high      = 0;
        @(negedge clock);
        while (!bus_pause) begin
            waited++;
            if (waited > TIMEOUT)
                stop_with_error("bus_pause never rose after a write request");
            @(negedge clock);
        end
        sq_seen_a = sq_reset_a; // Pulses exist only in the write cycle
        sq_seen_b = sq_reset_b;
        while (bus_pause) begin
            high++;
            if (high > TIMEOUT)
                stop_with_error("bus_pause stayed high after a write");
            @(negedge clock);
        end
        ack_seen  = int_acks;
        bus_write = 1'b0;
        check_equal("bus_pause high cycles", high, 1);
    endtask

    task automatic expect_read(input string name, input mem_pkg::word_t addr,
                               input mem_pkg::word_t exp);
        bus_addr  = addr;
        bus_write = 1'b0;
        @(negedge clock); // Data follows one cycle after the address
        check_equal(name, bus_rdata, exp);
    endtask

    task automatic write_ram(input int region, input int idx, input mem_pkg::mem_size_t size,
                             input logic [1:0] offset, input mem_pkg::word_t data);
        logic [3:0] lanes;
        lanes = lanes_for(size, offset);
        write_bus(ram_addr_of(region, idx) + offset, data, size);
        for (int lane = 0; lane < 4; lane++)
            if (lanes[lane])
                ram_ref[region][idx][8*lane +: 8] = data[8*lane +: 8];
    endtask

    task automatic random_ram_write(input int region);
        mem_pkg::mem_size_t size;
        logic [1:0]         offset;
        int                 idx;
        size   = mem_pkg::mem_size_t'($urandom_range(2));
        offset = 2'($urandom_range(3));
        idx    = $urandom_range(15);
        if (size == mem_pkg::size_word)
            offset = 2'd0;
        else if (size == mem_pkg::size_half)
            offset[0] = 1'b0; // Halves are aligned
        write_ram(region, idx, size, offset, $urandom);
        expect_read("bus_rdata", ram_addr_of(region, idx), ram_ref[region][idx]);
    endtask

    task automatic test_reset_values();
        check_equal("bus_pause", bus_pause, 0);
        check_equal("int_acks", int_acks, 0);
        check_equal("int_enable", int_enable, 0);
        check_equal("sq_reset_a", sq_reset_a, 0);
        check_equal("sq_reset_b", sq_reset_b, 0);
        check_equal("fifo_size_a", fifo_size_a, 0);
        check_equal("fifo_size_b", fifo_size_b, 0);
        expect_read("bus_rdata", IO_BASE + 4 * mem_pkg::IO_SOUNDCNT_IDX, 0);
    endtask

    task automatic test_ram_region(input int region, input int writes);
        for (int idx = 0; idx < 16; idx++)
            write_ram(region, idx, mem_pkg::size_word, 2'd0, $urandom);
        for (int n = 0; n < writes; n++)
            random_ram_write(region);
    endtask

    task automatic test_palettes();
        test_ram_region(1, 20);
        test_ram_region(2, 20);
        for (int idx = 0; idx < 16; idx++) begin
            expect_read("bus_rdata", ram_addr_of(1, idx), ram_ref[1][idx]);
            expect_read("bus_rdata", ram_addr_of(2, idx), ram_ref[2][idx]);
            gfx_bg_addr  = 7'(idx);
            gfx_obj_addr = 7'(15 - idx);
            @(negedge clock);
            check_equal("gfx_palette_bg_data", gfx_bg_data, ram_ref[1][idx]);
            check_equal("gfx_palette_obj_data", gfx_obj_data, ram_ref[2][15 - idx]);
        end
    endtask

    task automatic test_io_registers();
        mem_pkg::word_t key_addr, ie_addr, snd_addr, data;
        mem_pkg::half_t ie, ack;
        key_addr = IO_BASE + 4 * mem_pkg::IO_KEYINPUT_IDX;
        ie_addr  = IO_BASE + 4 * mem_pkg::IO_IE_IF_IDX;
        snd_addr = IO_BASE + 4 * mem_pkg::IO_SOUNDCNT_IDX;
        buttons  = 16'($urandom);
        reg_if   = 16'($urandom);
        ie       = 16'($urandom);
        ack      = 16'($urandom) | 16'h0001; // Never zero so the pulse shows
        data     = $urandom;
        write_bus(key_addr, data, mem_pkg::size_word);
        expect_read("bus_rdata keyinput", key_addr, {data[31:16], buttons});
        write_bus(ie_addr, {16'h0, ie}, mem_pkg::size_half);
        expect_read("bus_rdata ie_if", ie_addr, {reg_if, ie});
        check_equal("int_enable", int_enable, ie);
        write_bus(ie_addr + 2, {ack, 16'h0}, mem_pkg::size_half);
        check_equal("int_acks", ack_seen, ack);
        @(negedge clock);
        check_equal("int_acks", int_acks, 0);
        check_equal("int_enable", int_enable, ie);
        data = $urandom | SQ_BITS;
        write_bus(snd_addr, data, mem_pkg::size_word);
        check_equal("sq_reset_a", sq_seen_a, 1);
        check_equal("sq_reset_b", sq_seen_b, 1);
        expect_read("bus_rdata soundcnt", snd_addr, data);
        write_bus(snd_addr, data & ~SQ_BITS, mem_pkg::size_word);
        check_equal("sq_reset_a", sq_seen_a, 0);
        check_equal("sq_reset_b", sq_seen_b, 0);
    endtask

    task automatic test_fifo(input int which);
        mem_pkg::word_t addr, data;
        string          size_name;
        addr      = IO_BASE + 4 * (which ? mem_pkg::IO_FIFO_B_IDX : mem_pkg::IO_FIFO_A_IDX);
        size_name = which ? "fifo_size_b" : "fifo_size_a";
        fifo_ref.delete();
        for (int n = 0; n < 9; n++) begin
            data = $urandom;
            write_bus(addr, data, mem_pkg::size_word);
            if (n < 8)
                fifo_ref.push_back(data); // Ninth word meets a full FIFO
            check_equal(size_name, which ? fifo_size_b : fifo_size_a, fifo_ref.size());
            check_equal("other fifo size", which ? fifo_size_a : fifo_size_b, 0);
        end
        expect_read("bus_rdata fifo head", addr, fifo_ref[0]);
        for (int n = 0; n < 9; n++) begin
            if (n < 8)
                check_equal(which ? "fifo_data_b" : "fifo_data_a",
                            which ? fifo_data_b : fifo_data_a, fifo_ref.pop_front());
            fifo_read[which] = 1'b1; // Last pop hits an empty FIFO
            @(negedge clock);
            fifo_read[which] = 1'b0;
            check_equal(size_name, which ? fifo_size_b : fifo_size_a, fifo_ref.size());
        end
        write_bus(addr, $urandom, mem_pkg::size_word);
        fifo_clear[which] = 1'b1;
        @(negedge clock);
        fifo_clear[which] = 1'b0;
        check_equal(size_name, which ? fifo_size_b : fifo_size_a, 0);
    endtask

    task automatic test_dma_preempt();
        expect_read("bus_rdata", ram_addr_of(0, 3), ram_ref[0][3]);
        dma_active = 1'b1;
        expect_read("bus_rdata", ram_addr_of(0, 9), ram_ref[0][9]);
        @(negedge clock);
        dma_active = 1'b0;
        @(negedge clock); // Held word shows the cycle after the fall
        check_equal("bus_rdata preempted", bus_rdata, ram_ref[0][3]);
        @(negedge clock);
        check_equal("bus_rdata", bus_rdata, ram_ref[0][9]);
    endtask

    initial begin
        seed = 56621;
        void'($urandom(seed));
        reset        = 1'b1;
        bus_addr     = '0;
        bus_wdata    = '0;
        bus_size     = mem_pkg::size_word;
        bus_write    = 1'b0;
        dma_active   = 1'b0;
        gfx_bg_addr  = '0;
        gfx_obj_addr = '0;
        buttons      = '0;
        reg_if       = '0;
        fifo_read    = '0;
        fifo_clear   = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        test_reset_values();
        test_ram_region(0, 60);
        test_palettes();
        test_io_registers();
        test_fifo(0);
        test_fifo(1);
        test_dma_preempt();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/mem_pkg.sv
hdl/bus_front.sv
hdl/dual_port_ram.sv
hdl/ram_regions.sv
hdl/sound_fifo.sv
hdl/io_registers.sv
hdl/read_mux.sv
hdl/mem_top.sv
sim/tb_mem_top.sv
